// File: pic_defines.svh
// Interrupt controller constants shared by the packages and the RTL blocks
`ifndef PIC_DEFINES_SVH
`define PIC_DEFINES_SVH

// -------------------------------------------------------------------------
// programming model sizes
// -------------------------------------------------------------------------

// request lines on the one controller
`define PIC_NUM_IRQ 8

// wishbone data width
// port 0 sits on the low byte and port 1 on the high byte
`define PIC_DW 16

// -------------------------------------------------------------------------
// values after reset
// -------------------------------------------------------------------------

// vector base, only bits 7..3 are stored
`define PIC_VEC_RESET 8'h08

// mask with lines 2, 5, 6 and 7 blocked
`define PIC_IMR_RESET 8'hE4

`endif

// File: pic_reg_pkg.sv
// Register-side types for the init sequencer and the command words
`default_nettype none

package pic_reg_pkg;

  // -------------------------------------------------------------------------
  // init sequencer
  // -------------------------------------------------------------------------

  // ICW3 has no state of its own since only single mode is built
  typedef enum logic [1:0] {
    init_ready     = 2'd0,  // port 1 writes go to the mask
    init_wait_icw2 = 2'd1,  // after ICW1
    init_wait_icw4 = 2'd2   // after ICW2 when ic4 was set
  } init_state_e;

  // -------------------------------------------------------------------------
  // command words
  // -------------------------------------------------------------------------

  // OCW2 decoded on the SL and EOI bits only
  typedef enum logic [1:0] {
    ocw2_ns_eoi = 2'd0,  // clear the top in-service bit
    ocw2_s_eoi  = 2'd1,  // clear the level in bits 2..0
    ocw2_other  = 2'd2   // rotate and set priority, no effect
  } ocw2_cmd_e;

  // ICW1 bits 3, 1 and 0
  typedef struct packed {
    logic ltim;  // level triggered
    logic sngl;  // no cascade
    logic ic4;   // ICW4 follows ICW2
  } icw1_t;

  // ICW4 bit 1
  typedef struct packed {
    logic aeoi;  // auto end of interrupt
  } icw4_t;

endpackage

`default_nettype wire

// File: pic_irq_pkg.sv
// Interrupt-side types for request vectors and priority levels
`default_nettype none

`include "pic_defines.svh"

package pic_irq_pkg;

  // -------------------------------------------------------------------------
  // request side
  // -------------------------------------------------------------------------

  // one bit per line
  // bit 0 has the highest priority
  typedef logic [`PIC_NUM_IRQ-1:0] irq_vec_t;

  // level number of one line
  // also the low three bits of the vector
  typedef logic [$clog2(`PIC_NUM_IRQ)-1:0] irq_lvl_t;

endpackage

`default_nettype wire

// File: pic_ctl_if.sv
// Control and status link between the register block and the interrupt core
`timescale 1ns/10ps
`default_nettype none

interface pic_ctl_if;

  // configuration held by the register block
  pic_irq_pkg::irq_vec_t imr;           // set bit blocks its line
  logic                  ltim;          // level mode
  logic                  aeoi;          // auto eoi on acknowledge
  logic [4:0]            vec_base;      // ICW2 bits 7..3
  logic                  init_clr;      // pulse on every ICW1 write

  // end of interrupt command, one cycle
  logic                  eoi_req;
  logic                  eoi_specific;  // level given by software
  pic_irq_pkg::irq_lvl_t eoi_lvl;

  // status for register reads
  pic_irq_pkg::irq_vec_t irr;
  pic_irq_pkg::irq_vec_t isr;

  modport regs (
    output imr, ltim, aeoi, vec_base, init_clr,
    output eoi_req, eoi_specific, eoi_lvl,
    input  irr, isr
  );

  modport core (
    input  imr, ltim, aeoi, vec_base, init_clr,
    input  eoi_req, eoi_specific, eoi_lvl,
    output irr, isr
  );

endinterface

`default_nettype wire

// File: pic_wb_regs.sv
// Wishbone register block of the interrupt controller with init sequencer and read mux
`timescale 1ns/10ps
`default_nettype none

`include "pic_defines.svh"

module pic_wb_regs (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 wb_stb_i,
  input  wire                 wb_cyc_i,
  input  wire                 wb_we_i,
  input  wire [1:0]           wb_sel_i,
  input  wire [`PIC_DW-1:0]   wb_dat_i,
  output logic [`PIC_DW-1:0]  wb_dat_o,
  output logic                wb_ack_o,
  pic_ctl_if.regs             ctl
);

  localparam logic [7:0] vec_reset = `PIC_VEC_RESET;

  logic                      stb_q;        // strobe one cycle back
  logic                      start;        // first cycle of an access
  logic                      sel_lo;       // port 0
  logic                      sel_hi;       // port 1
  logic                      wr_lo;
  logic                      wr_hi;
  logic                      rd_lo;
  logic                      rd_hi;
  logic                      ack_q;
  logic                      wr_icw1_q;
  logic                      wr_icw2_q;
  logic                      wr_icw4_q;
  logic                      wr_ocw1_q;
  logic                      wr_ocw2_q;
  logic                      wr_ocw3_q;
  logic [7:0]                wdat_q;       // byte of the last write
  pic_reg_pkg::init_state_e  init_state;
  pic_reg_pkg::icw1_t        icw1_q;
  pic_reg_pkg::icw4_t        icw4_q;
  logic [4:0]                vec_base_q;
  pic_irq_pkg::irq_vec_t     imr_q;
  logic                      read_isr_q;   // OCW3 ris
  pic_reg_pkg::ocw2_cmd_e    ocw2_cmd;
  logic [`PIC_DW-1:0]        dat_q;

  // -------------------------------------------------------------------------
  // access detection
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
      stb_q <= 1'b0;
    else
      stb_q <= wb_stb_i;

  assign start  = wb_stb_i & wb_cyc_i & ~stb_q;  // rising strobe only
  assign sel_lo = (wb_sel_i == 2'b01);
  assign sel_hi = (wb_sel_i == 2'b10);            // other selects get no ack

  assign wr_lo = start & wb_we_i & sel_lo;
  assign wr_hi = start & wb_we_i & sel_hi;
  assign rd_lo = start & ~wb_we_i & sel_lo;
  assign rd_hi = start & ~wb_we_i & sel_hi;

  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= wr_lo | wr_hi | rd_lo | rd_hi;     // exactly one cycle later

  assign wb_ack_o = ack_q;

  // -------------------------------------------------------------------------
  // write decode, one cycle behind the start
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
    begin
      wr_icw1_q <= 1'b0;
      wr_icw2_q <= 1'b0;
      wr_icw4_q <= 1'b0;
      wr_ocw1_q <= 1'b0;
      wr_ocw2_q <= 1'b0;
      wr_ocw3_q <= 1'b0;
    end
    else
    begin
      wr_icw1_q <= wr_lo & wb_dat_i[4];
      wr_ocw2_q <= wr_lo & (wb_dat_i[4:3] == 2'b00);
      wr_ocw3_q <= wr_lo & (wb_dat_i[4:3] == 2'b01);
      // port 1 meaning depends on the init step
      wr_icw2_q <= wr_hi & (init_state == pic_reg_pkg::init_wait_icw2);
      wr_icw4_q <= wr_hi & (init_state == pic_reg_pkg::init_wait_icw4);
      wr_ocw1_q <= wr_hi & (init_state == pic_reg_pkg::init_ready);
    end

  always_ff @(posedge wb_clk_i)
    if (start)
      wdat_q <= sel_hi ? wb_dat_i[15:8] : wb_dat_i[7:0];

  // -------------------------------------------------------------------------
  // init sequencer
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
      init_state <= pic_reg_pkg::init_ready;
    else if (wr_icw1_q)                           // ICW1 restarts from any step
      init_state <= pic_reg_pkg::init_wait_icw2;
    else if (wr_icw2_q)
      init_state <= icw1_q.ic4 ? pic_reg_pkg::init_wait_icw4 : pic_reg_pkg::init_ready;
    else if (wr_icw4_q)
      init_state <= pic_reg_pkg::init_ready;

  // -------------------------------------------------------------------------
  // ICW and OCW registers
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
    begin
      icw1_q     <= '{ltim: 1'b0, sngl: 1'b1, ic4: 1'b0};  // edge, single
      vec_base_q <= vec_reset[7:3];
      icw4_q     <= '{aeoi: 1'b0};
      imr_q      <= `PIC_IMR_RESET;
      read_isr_q <= 1'b1;
    end
    else
    begin
      if (wr_icw1_q)
      begin
        icw1_q     <= '{ltim: wdat_q[3], sngl: wdat_q[1], ic4: wdat_q[0]};
        icw4_q     <= '{aeoi: 1'b0};           // ICW4 bits cleared by ICW1
        imr_q      <= `PIC_IMR_RESET;
        read_isr_q <= 1'b1;
      end
      if (wr_icw2_q)
        vec_base_q <= wdat_q[7:3];
      if (wr_icw4_q)
        icw4_q <= '{aeoi: wdat_q[1]};
      if (wr_ocw1_q)
        imr_q <= wdat_q;
      if (wr_ocw3_q && wdat_q[1])               // rr bit gates ris
        read_isr_q <= wdat_q[0];
    end

  // OCW2 on SL and EOI, R ignored
  always_comb
    case (wdat_q[6:5])
      2'b01:   ocw2_cmd = pic_reg_pkg::ocw2_ns_eoi;
      2'b11:   ocw2_cmd = pic_reg_pkg::ocw2_s_eoi;
      default: ocw2_cmd = pic_reg_pkg::ocw2_other;
    endcase

  assign ctl.eoi_req      = wr_ocw2_q & (ocw2_cmd != pic_reg_pkg::ocw2_other);
  assign ctl.eoi_specific = (ocw2_cmd == pic_reg_pkg::ocw2_s_eoi);
  assign ctl.eoi_lvl      = wdat_q[2:0];

  assign ctl.imr      = imr_q;
  assign ctl.ltim     = icw1_q.ltim;
  assign ctl.aeoi     = icw4_q.aeoi;
  assign ctl.vec_base = vec_base_q;
  assign ctl.init_clr = wr_icw1_q;

  // -------------------------------------------------------------------------
  // read mux, registered so data comes with the ack
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
      dat_q <= '0;
    else
    begin
      dat_q[15:8] <= rd_hi ? imr_q : 8'h00;
      dat_q[7:0]  <= rd_lo ? (read_isr_q ? ctl.isr : ctl.irr) : 8'h00;
    end

  assign wb_dat_o = dat_q;

  // a new access needs the strobe low first so acks never touch
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wishbone ack high two cycles in a row");

  // ICW2 may only close a sequence begun in single mode
  a_single_mode: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wr_icw2_q |-> icw1_q.sngl)
    else $error("ICW1 requested cascade mode");

endmodule

`default_nettype wire

// File: pic_irq_core.sv
// Interrupt core with request capture, nested priority, in-service tracking and vector
`timescale 1ns/10ps
`default_nettype none

`include "pic_defines.svh"

module pic_irq_core (
  input  wire                        wb_clk_i,
  input  wire                        wb_rst_i,
  input  wire pic_irq_pkg::irq_vec_t irq_i,
  input  wire                        inta_i,
  output logic                       intr_o,
  output logic [7:0]                 vec_o,
  output logic                       vec_en_o,
  pic_ctl_if.core                    ctl
);

  pic_irq_pkg::irq_vec_t irq_s1;       // sync stage
  pic_irq_pkg::irq_vec_t irq_s2;       // previous value for edges
  pic_irq_pkg::irq_vec_t set_irr;
  pic_irq_pkg::irq_vec_t irr_q;
  pic_irq_pkg::irq_vec_t isr_q;
  pic_irq_pkg::irq_vec_t masked;
  pic_irq_pkg::irq_vec_t isr_set;
  pic_irq_pkg::irq_vec_t eoi_clr;
  pic_irq_pkg::irq_vec_t aeoi_clr_q;
  pic_irq_pkg::irq_lvl_t req_lvl;      // best unmasked request
  pic_irq_pkg::irq_lvl_t isr_top;      // best level in service
  pic_irq_pkg::irq_lvl_t lvl_q;        // level behind intr_o
  logic                  req_ok;
  logic                  lvl_vld_q;
  logic                  intr_q;
  logic                  inta_q;
  logic                  ack_edge;
  logic                  freeze;       // acknowledge in progress

  // lowest set index, which is the highest priority
  function automatic pic_irq_pkg::irq_lvl_t first_set(input pic_irq_pkg::irq_vec_t v);
    pic_irq_pkg::irq_lvl_t lvl;
    lvl = '0;
    for (int i = `PIC_NUM_IRQ - 1; i >= 0; i--)
      if (v[i])
        lvl = pic_irq_pkg::irq_lvl_t'(i);
    return lvl;
  endfunction

  // -------------------------------------------------------------------------
  // request capture
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
    begin
      irq_s1 <= '0;
      irq_s2 <= '0;
    end
    else
    begin
      irq_s1 <= irq_i;
      irq_s2 <= irq_s1;
    end

  assign set_irr = ctl.ltim ? irq_s1 : (irq_s1 & ~irq_s2);  // level or rising edge

  // -------------------------------------------------------------------------
  // priority resolution
  // -------------------------------------------------------------------------
  assign masked  = irr_q & ~ctl.imr;
  assign req_lvl = first_set(masked);
  assign isr_top = first_set(isr_q);

  // full nesting blocks a request at or below the top in-service level
  assign req_ok = (|masked) & ~((|isr_q) & (isr_top <= req_lvl));

  // -------------------------------------------------------------------------
  // acknowledge
  // -------------------------------------------------------------------------
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i)
      inta_q <= 1'b0;
    else
      inta_q <= inta_i;

  assign ack_edge = inta_i & ~inta_q;
  assign freeze   = inta_i | inta_q;   // covers the cycle after inta falls
  assign isr_set  = (ack_edge & lvl_vld_q) ? (pic_irq_pkg::irq_vec_t'(1) << lvl_q) : '0;

  // hold level and intr, frozen while the vector is out
  always_ff @(posedge wb_clk_i)
    if (wb_rst_i || ctl.init_clr)
    begin
      intr_q    <= 1'b0;
      lvl_vld_q <= 1'b0;
      lvl_q     <= '0;
    end
    else if (freeze)
      intr_q <= 1'b0;
    else
    begin
      intr_q    <= req_ok;
      lvl_vld_q <= req_ok;
      lvl_q     <= req_lvl;
    end

  // -------------------------------------------------------------------------
  // IRR and ISR
  // -------------------------------------------------------------------------
  always_comb
  begin
    eoi_clr = '0;
    if (ctl.eoi_req)                   // non-specific takes the top ISR bit
      eoi_clr[ctl.eoi_specific ? ctl.eoi_lvl : isr_top] = 1'b1;
  end

  always_ff @(posedge wb_clk_i)
    if (wb_rst_i || ctl.init_clr)
    begin
      irr_q      <= '0;
      isr_q      <= '0;
      aeoi_clr_q <= '0;
    end
    else
    begin
      irr_q      <= (irr_q & ~isr_set) | set_irr;  // held level sets it again
      isr_q      <= (isr_q | isr_set) & ~eoi_clr & ~aeoi_clr_q;
      aeoi_clr_q <= ctl.aeoi ? isr_set : '0;       // ISR bit lives one cycle
    end

  assign ctl.irr = irr_q;
  assign ctl.isr = isr_q;

  // -------------------------------------------------------------------------
  // outputs
  // -------------------------------------------------------------------------
  assign intr_o   = intr_q;
  assign vec_o    = {ctl.vec_base, lvl_q};
  assign vec_en_o = freeze;

  // no stale request survives a restart of the init sequence
  a_init_quiet: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ctl.init_clr |=> !intr_o)
    else $error("intr_o high right after ICW1");

  // vector on the bus only during acknowledge and one cycle after
  a_vec_window: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    vec_en_o |-> (inta_i || $past(inta_i)))
    else $error("vector driven outside acknowledge");

endmodule

`default_nettype wire

// File: pic_top.sv
// Interrupt controller top level joining the Wishbone registers and the interrupt core
`timescale 1ns/10ps
`default_nettype none

`include "pic_defines.svh"

module pic_top (
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_we_i,
  input  wire [1:0]              wb_sel_i,
  input  wire [`PIC_DW-1:0]      wb_dat_i,
  output logic [`PIC_DW-1:0]     wb_dat_o,
  output logic                   wb_ack_o,
  input  wire [`PIC_NUM_IRQ-1:0] irq_i,
  output logic                   intr_o,
  input  wire                    inta_i
);

  logic [`PIC_DW-1:0] reg_dat;   // register read data
  logic [7:0]         vec;
  logic               vec_en;

  pic_ctl_if ctl ();

  pic_wb_regs u_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (reg_dat),
    .wb_ack_o (wb_ack_o),
    .ctl      (ctl.regs)
  );

  pic_irq_core u_core (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .irq_i    (irq_i),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .vec_o    (vec),
    .vec_en_o (vec_en),
    .ctl      (ctl.core)
  );

  // vector takes the low byte during acknowledge
  assign wb_dat_o = vec_en ? {{(`PIC_DW - 8){1'b0}}, vec} : reg_dat;

endmodule

`default_nettype wire

// File: tb_pic.sv
// Directed testbench for the Wishbone interrupt controller
`timescale 1ns/10ps
`default_nettype none

`include "pic_defines.svh"

module tb_pic;

  localparam int num_tests = 6;

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic                  wb_stb_i;
  logic                  wb_cyc_i;
  logic                  wb_we_i;
  logic [1:0]            wb_sel_i;
  logic [`PIC_DW-1:0]    wb_dat_i;
  logic [`PIC_DW-1:0]    wb_dat_o;
  logic                  wb_ack_o;
  pic_irq_pkg::irq_vec_t irq_i;
  logic                  intr_o;
  logic                  inta_i;

  int                    errors;
  int                    checks;
  int                    tests_run;
  int                    err_mark;     // error count at test start
  int unsigned           rnd;
  pic_irq_pkg::irq_lvl_t rnd_lvl;

  pic_top uut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .irq_i    (irq_i),
    .intr_o   (intr_o),
    .inta_i   (inta_i)
  );

  initial
  begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;  // 40 ns period
  end

  // -------------------------------------------------------------------------
  // bus and interrupt helpers
  // -------------------------------------------------------------------------
  task automatic bus_cycle(input logic we, input logic port, input logic [7:0] wbyte,
                           output logic [7:0] rbyte);
    int   n;
    int   ack_at;                                              // cycle the ack came in
    logic got_ack;
    n       = 0;
    ack_at  = 0;
    got_ack = 1'b0;
    rbyte   = 8'h00;
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    wb_we_i  <= we;
    wb_sel_i <= port ? 2'b10 : 2'b01;                          // byte lanes
    wb_dat_i <= port ? {wbyte, 8'h00} : {8'h00, wbyte};
    while (!got_ack && n < 4)                                  // ack due after one cycle
    begin
      @(negedge wb_clk_i);
      if (wb_ack_o)
      begin
        got_ack = 1'b1;
        ack_at  = n;
        rbyte   = port ? wb_dat_o[15:8] : wb_dat_o[7:0];
      end
      n++;
    end
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!got_ack)
    begin
      errors++;
      $display("no ack for a bus %s on port %0d", we ? "write" : "read", port);
    end
    else if (ack_at != 1)
    begin
      errors++;
      $display("ack for a bus %s on port %0d came %0d cycles after the strobe",
               we ? "write" : "read", port, ack_at);
    end
  endtask

  task automatic wb_write(input logic port, input logic [7:0] wbyte);
    logic [7:0] unused;
    bus_cycle(1'b1, port, wbyte, unused);
  endtask

  task automatic wb_read(input logic port, output logic [7:0] rbyte);
    bus_cycle(1'b0, port, 8'h00, rbyte);
  endtask

  task automatic check_byte(input string sig, input pic_irq_pkg::irq_vec_t got,
                            input pic_irq_pkg::irq_vec_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_lvl(input string sig, input pic_irq_pkg::irq_lvl_t got,
                           input pic_irq_pkg::irq_lvl_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s got %h expected %h", sig, got, exp);
    end
  endtask

  // read back one port and compare
  task automatic read_expect(input logic port, input string sig, input logic [7:0] exp);
    logic [7:0] rd;
    wb_read(port, rd);
    check_byte(sig, rd, exp);
  endtask

  // ICW1, ICW2 base 20, ICW4, then mask cleared
  task automatic init_pic(input logic level, input logic aeoi);
    wb_write(1'b0, 8'h13 | {4'b0, level, 3'b0});  // single, ic4
    wb_write(1'b1, 8'h20);
    wb_write(1'b1, {6'b0, aeoi, 1'b1});           // 8086 mode
    wb_write(1'b1, 8'h00);                        // OCW1
  endtask

  task automatic pulse_irq(input pic_irq_pkg::irq_vec_t lines);
    @(posedge wb_clk_i);
    irq_i <= lines;
    repeat (2) @(posedge wb_clk_i);
    irq_i <= '0;
  endtask

  // wait for intr_o, then run one acknowledge and capture the vector
  task automatic take_irq(output pic_irq_pkg::irq_vec_t vec);
    int   n;
    logic seen;
    seen = 1'b0;
    vec  = '0;
    for (n = 0; n < 8 && !seen; n++)
    begin
      @(negedge wb_clk_i);
      seen = intr_o;
    end
    if (!seen)
    begin
      errors++;
      $display("intr_o did not rise within 8 cycles");
    end
    else
    begin
      @(posedge wb_clk_i);
      inta_i <= 1'b1;
      @(negedge wb_clk_i);
      vec = wb_dat_o[7:0];                      // vector on the low byte
      @(posedge wb_clk_i);
      inta_i <= 1'b0;
      repeat (2) @(posedge wb_clk_i);           // window closes
    end
  endtask

  task automatic expect_quiet(input string why);
    int n;
    for (n = 0; n < 8; n++)
    begin
      @(negedge wb_clk_i);
      if (intr_o)
      begin
        errors++;
        $display("intr_o rose although %s", why);
        break;
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %-20s %s", tests_run, name, (errors == err_mark) ? "ok" : "FAILED");
    err_mark = errors;
  endtask

  // -------------------------------------------------------------------------
  // directed tests
  // -------------------------------------------------------------------------
  task automatic reset_defaults;
    read_expect(1'b1, "imr", 8'hE4);
    read_expect(1'b0, "isr", 8'h00);
    report_test("reset defaults");
  endtask

  task automatic init_and_mask;
    init_pic(1'b0, 1'b0);
    read_expect(1'b1, "imr", 8'h00);
    report_test("init and mask");
  endtask

  task automatic edge_and_eoi;
    pic_irq_pkg::irq_vec_t vec;
    pulse_irq(8'h08);
    take_irq(vec);
    check_byte("vector", vec, 8'h23);
    read_expect(1'b0, "isr", 8'h08);
    wb_write(1'b0, 8'h20);                      // non-specific eoi
    read_expect(1'b0, "isr", 8'h00);
    wb_write(1'b0, 8'h0A);                      // OCW3 read irr
    read_expect(1'b0, "irr", 8'h00);
    wb_write(1'b0, 8'h0B);                      // back to isr
    report_test("edge and eoi");
  endtask

  task automatic priority_nesting;
    pic_irq_pkg::irq_vec_t vec;
    pulse_irq(8'h24);                           // lines 5 and 2
    take_irq(vec);
    check_byte("vector", vec, 8'h22);
    expect_quiet("level 2 was in service");
    wb_write(1'b0, 8'h62);                      // specific eoi, level 2
    take_irq(vec);
    check_byte("vector", vec, 8'h25);
    wb_write(1'b0, 8'h20);
    read_expect(1'b0, "isr", 8'h00);
    report_test("priority nesting");
  endtask

  task automatic mask_and_level;
    pic_irq_pkg::irq_vec_t vec;
    wb_write(1'b1, 8'h40);                      // block line 6
    pulse_irq(8'h40);
    expect_quiet("line 6 was masked");
    wb_write(1'b0, 8'h0A);
    read_expect(1'b0, "irr", 8'h40);
    init_pic(1'b1, 1'b0);                       // level mode
    @(posedge wb_clk_i);
    irq_i <= 8'h10;                             // line 4 held
    take_irq(vec);
    check_byte("vector", vec, 8'h24);
    wb_write(1'b0, 8'h20);
    take_irq(vec);                              // still high, so again
    check_byte("vector", vec, 8'h24);
    @(posedge wb_clk_i);
    irq_i <= '0;
    wb_write(1'b0, 8'h20);
    report_test("mask and level");
  endtask

  task automatic auto_eoi;
    pic_irq_pkg::irq_vec_t vec;
    init_pic(1'b0, 1'b1);
    pulse_irq(pic_irq_pkg::irq_vec_t'(1) << rnd_lvl);
    take_irq(vec);
    check_byte("vector", vec, 8'h20 | {5'b0, rnd_lvl});
    check_lvl("vector level", vec[2:0], rnd_lvl);
    wb_write(1'b0, 8'h0B);                       // OCW3 read isr
    read_expect(1'b0, "isr", 8'h00);             // cleared without software
    report_test("auto eoi");
  endtask

  // -------------------------------------------------------------------------
  // main sequence and watchdog
  // -------------------------------------------------------------------------
  initial
  begin
    wb_rst_i  = 1'b1;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_sel_i  = 2'b00;
    wb_dat_i  = '0;
    irq_i     = '0;
    inta_i    = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    err_mark  = 0;
    rnd       = $urandom(86);
    rnd_lvl   = rnd[2:0];
    repeat (5) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    reset_defaults();
    init_and_mask();
    edge_and_eoi();
    priority_nesting();
    mask_and_level();
    auto_eoi();
    $display("tests %0d  checks %0d  errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    repeat (num_tests * 400) @(posedge wb_clk_i);
    $display("watchdog expired after %0d cycles", num_tests * 400);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
pic_reg_pkg.sv
pic_irq_pkg.sv
pic_ctl_if.sv
pic_wb_regs.sv
pic_irq_core.sv
pic_top.sv
tb_pic.sv

// File: Makefile
# Verilator lint, simulation and clean for the interrupt controller

VERILATOR ?= verilator
TOP       ?= tb_pic
RTL_TOP   ?= pic_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
